//--- list.f
source/mems_pkg.sv
source/mems_axis_sequencer.sv
source/mems_spi_master.sv
source/mems_sample_unpack.sv
source/mems_spi_top.sv
verif/mems_slave_model.sv
verif/tb_mems_spi_top.sv

//--- run.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and scans the log for the result

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps -j 0 \
  -f list.f --top-module tb_mems_spi_top -o tb_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "TEST PASS" "$LOG"; then
  exit 0
fi
exit 1

//--- source/mems_axis_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module mems_axis_sequencer import mems_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic               sample_req,
  input  logic               busy,
  input  logic               new_data,
  output logic [FRAME_W-1:0] cmd_frame,
  output logic               start,
  output logic [1:0]         axis_idx,
  output logic               rd_frame,
  output logic               seq_busy
);

  typedef enum logic [1:0] {
    ST_CFG,  // control write after reset
    ST_WAIT, // frame in flight
    ST_IDLE
  } state_t;

  localparam logic [1:0] LAST_AXIS = 2'(NUM_AXES - 1);

  state_t             state_q, state_d;
  logic               start_q, start_d;
  logic [1:0]         axis_q, axis_d;
  logic               rd_q, rd_d;
  logic [FRAME_W-1:0] cmd_q, cmd_d;

  function automatic logic [FRAME_W-1:0] read_cmd(input logic [1:0] idx);
    logic [ADDR_W-1:0] addr;
    case (idx)
      2'd0:    addr = REG_OUT_X;
      2'd1:    addr = REG_OUT_Y;
      default: addr = REG_OUT_Z;
    endcase
    read_cmd = {1'b1, addr, {DATA_W{1'b0}}};
  endfunction

  always_comb begin
    state_d = state_q;
    start_d = 1'b0;
    axis_d  = axis_q;
    rd_d    = rd_q;
    cmd_d   = cmd_q;
    case (state_q)
      ST_CFG: begin
        if (!busy) begin
          cmd_d   = {1'b0, REG_CTRL, CTRL_INIT};
          start_d = 1'b1;
          state_d = ST_WAIT;
        end
      end
      ST_WAIT: begin
        if (new_data) begin
          if (rd_q && axis_q != LAST_AXIS) begin // next axis of this sample
            axis_d  = axis_q + 2'd1;
            cmd_d   = read_cmd(axis_q + 2'd1);
            start_d = 1'b1;
          end else begin
            state_d = ST_IDLE; // config done or z delivered
          end
        end
      end
      default: begin
        if (sample_req && !busy) begin // requests while busy are dropped
          axis_d  = 2'd0;
          rd_d    = 1'b1;
          cmd_d   = read_cmd(2'd0);
          start_d = 1'b1;
          state_d = ST_WAIT;
        end
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= ST_CFG;
      start_q <= 1'b0;
      axis_q  <= 2'd0;
      rd_q    <= 1'b0;
    end else begin
      state_q <= state_d;
      start_q <= start_d;
      axis_q  <= axis_d;
      rd_q    <= rd_d;
    end
  end

  // command word, stable until the frame's new_data
  always_ff @(posedge clk) begin
    cmd_q <= cmd_d;
  end

  assign cmd_frame = cmd_q;
  assign start     = start_q;
  assign axis_idx  = axis_q;
  assign rd_frame  = rd_q;
  assign seq_busy  = (state_q != ST_IDLE);

  // frame ends only come back for frames this block launched
  frame_end_a: assert property (@(posedge clk) disable iff (rst)
    new_data |-> state_q == ST_WAIT);

endmodule

`default_nettype wire

//--- source/mems_pkg.sv
`default_nettype none

package mems_pkg;

  // 24-bit link frame: {read flag, address, data}
  localparam int FRAME_W = 24;
  localparam int ADDR_W  = 7;
  localparam int DATA_W  = 16;

  // sensor register map
  localparam logic [ADDR_W-1:0] REG_CTRL  = 7'h20;
  localparam logic [ADDR_W-1:0] REG_OUT_X = 7'h28;
  localparam logic [ADDR_W-1:0] REG_OUT_Y = 7'h2A;
  localparam logic [ADDR_W-1:0] REG_OUT_Z = 7'h2C;

  // 100 Hz output rate, all three axes enabled
  localparam logic [DATA_W-1:0] CTRL_INIT = 16'h0057;

  // reads per sample (x, y, z)
  localparam int NUM_AXES = 3;

endpackage

`default_nettype wire

//--- source/mems_sample_unpack.sv
`timescale 1ns/100ps
`default_nettype none

module mems_sample_unpack import mems_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic               new_data,
  input  logic [FRAME_W-1:0] rx_frame,
  input  logic               rd_frame,
  input  logic [1:0]         axis_idx,
  output logic [DATA_W-1:0]  x_data,
  output logic [DATA_W-1:0]  y_data,
  output logic [DATA_W-1:0]  z_data,
  output logic               sample_valid
);

  localparam logic [1:0] LAST_AXIS = 2'(NUM_AXES - 1);

  logic [DATA_W-1:0] field;
  logic              capture;
  logic              last_axis;
  logic [DATA_W-1:0] hold_x_q, hold_y_q;
  logic [DATA_W-1:0] x_q, y_q, z_q;
  logic              valid_q;

  assign field     = rx_frame[DATA_W-1:0]; // data field of the returned frame
  assign capture   = new_data & rd_frame;  // config write echo is ignored
  assign last_axis = (axis_idx == LAST_AXIS);

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= capture & last_axis;
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      case (axis_idx)
        2'd0:    hold_x_q <= field;
        2'd1:    hold_y_q <= field;
        default: ;
      endcase
    end
    // all three outputs move together on the z frame
    if (capture && last_axis) begin
      x_q <= hold_x_q;
      y_q <= hold_y_q;
      z_q <= field;
    end
  end

  assign x_data       = x_q;
  assign y_data       = y_q;
  assign z_data       = z_q;
  assign sample_valid = valid_q;

  single_pulse_a: assert property (@(posedge clk) disable iff (rst)
    sample_valid |=> !sample_valid);

endmodule

`default_nettype wire

//--- source/mems_spi_master.sv
`timescale 1ns/100ps
`default_nettype none

module mems_spi_master import mems_pkg::*; #(
  parameter int CLK_DIV = 2
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               miso,
  input  logic [FRAME_W-1:0] cmd_frame,
  input  logic               start,
  output logic               sck,
  output logic               mosi,
  output logic               cs,
  output logic               busy,
  output logic               new_data,
  output logic [FRAME_W-1:0] rx_frame
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WAIT_HALF,
    ST_TRANSFER,
    ST_CS_TAIL,
    ST_GAP
  } state_t;

  localparam int BIT_W = $clog2(FRAME_W);

  // divider counts one sck period, sck high in its upper half
  localparam logic [CLK_DIV-1:0] DIV_LAST  = '1;
  localparam logic [CLK_DIV-1:0] HALF_LAST = CLK_DIV'((2 ** (CLK_DIV - 1)) - 1);
  localparam logic [BIT_W-1:0]   LAST_BIT  = BIT_W'(FRAME_W - 1);

  state_t             state_q, state_d;
  logic [CLK_DIV-1:0] div_q, div_d;
  logic [BIT_W-1:0]   bit_q, bit_d;
  logic [FRAME_W-1:0] shift_q, shift_d;
  logic [FRAME_W-1:0] rx_q, rx_d;
  logic               mosi_q, mosi_d;
  logic               cs_q, cs_d;
  logic               new_data_q, new_data_d;

  always_comb begin
    state_d    = state_q;
    div_d      = div_q + 1'b1;
    bit_d      = bit_q;
    shift_d    = shift_q;
    rx_d       = rx_q;
    mosi_d     = mosi_q;
    cs_d       = cs_q;
    new_data_d = 1'b0;
    case (state_q)
      ST_IDLE: begin
        div_d = '0;
        bit_d = '0;
        if (start) begin
          cs_d    = 1'b0;
          state_d = ST_WAIT_HALF;
        end
      end
      ST_WAIT_HALF: begin
        shift_d = cmd_frame;
        mosi_d  = cmd_frame[FRAME_W-1]; // msb valid before first rise
        if (div_q == DIV_LAST) begin
          div_d   = '0;
          state_d = ST_TRANSFER;
        end
      end
      ST_TRANSFER: begin
        if (div_q == HALF_LAST) begin
          shift_d = {shift_q[FRAME_W-2:0], miso}; // sample just before sck rises
        end
        if (div_q == DIV_LAST) begin // sck falls here
          if (bit_q == LAST_BIT) begin
            rx_d    = shift_q;
            state_d = ST_CS_TAIL;
          end else begin
            bit_d  = bit_q + 1'b1;
            mosi_d = shift_q[FRAME_W-1];
          end
        end
      end
      ST_CS_TAIL: begin
        if (div_q == HALF_LAST) begin
          div_d   = '0;
          cs_d    = 1'b1;
          state_d = ST_GAP;
        end
      end
      ST_GAP: begin
        if (div_q == HALF_LAST) begin
          mosi_d     = 1'b0;
          new_data_d = 1'b1;
          state_d    = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q    <= ST_IDLE;
      div_q      <= '0;
      bit_q      <= '0;
      mosi_q     <= 1'b0;
      cs_q       <= 1'b1; // deselected out of reset
      new_data_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      div_q      <= div_d;
      bit_q      <= bit_d;
      mosi_q     <= mosi_d;
      cs_q       <= cs_d;
      new_data_q <= new_data_d;
    end
  end

  always_ff @(posedge clk) begin
    shift_q <= shift_d;
    rx_q    <= rx_d;
  end

  assign sck      = (state_q == ST_TRANSFER) & div_q[CLK_DIV-1];
  assign mosi     = mosi_q;
  assign cs       = cs_q;
  assign busy     = (state_q != ST_IDLE);
  assign new_data = new_data_q;
  assign rx_frame = rx_q;

  // a frame is only launched into an idle master
  start_idle_a: assert property (@(posedge clk) disable iff (rst) start |-> !busy);

endmodule

`default_nettype wire

//--- source/mems_spi_top.sv
`timescale 1ns/100ps
`default_nettype none

module mems_spi_top import mems_pkg::*; #(
  parameter int CLK_DIV = 2
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              sample_req,
  input  logic              miso,
  output logic              sck,
  output logic              mosi,
  output logic              cs,
  output logic              seq_busy,
  output logic              sample_valid,
  output logic [DATA_W-1:0] x_data,
  output logic [DATA_W-1:0] y_data,
  output logic [DATA_W-1:0] z_data
);

  logic [FRAME_W-1:0] cmd_frame;
  logic [FRAME_W-1:0] rx_frame;
  logic               start;
  logic               busy;
  logic               new_data;
  logic [1:0]         axis_idx;
  logic               rd_frame;

  mems_axis_sequencer u_seq (
    .clk        (clk),
    .rst        (rst),
    .sample_req (sample_req),
    .busy       (busy),
    .new_data   (new_data),
    .cmd_frame  (cmd_frame),
    .start      (start),
    .axis_idx   (axis_idx),
    .rd_frame   (rd_frame),
    .seq_busy   (seq_busy)
  );

  mems_spi_master #(.CLK_DIV(CLK_DIV)) u_spi (
    .clk       (clk),
    .rst       (rst),
    .miso      (miso),
    .cmd_frame (cmd_frame),
    .start     (start),
    .sck       (sck),
    .mosi      (mosi),
    .cs        (cs),
    .busy      (busy),
    .new_data  (new_data),
    .rx_frame  (rx_frame)
  );

  mems_sample_unpack u_unpack (
    .clk          (clk),
    .rst          (rst),
    .new_data     (new_data),
    .rx_frame     (rx_frame),
    .rd_frame     (rd_frame),
    .axis_idx     (axis_idx),
    .x_data       (x_data),
    .y_data       (y_data),
    .z_data       (z_data),
    .sample_valid (sample_valid)
  );

endmodule

`default_nettype wire

//--- verif/mems_slave_model.sv
`timescale 1ns/100ps
`default_nettype none

module mems_slave_model import mems_pkg::*; (
  input  logic               sck,
  input  logic               mosi,
  input  logic               cs,
  output logic               miso,
  input  logic [DATA_W-1:0]  reg_x,
  input  logic [DATA_W-1:0]  reg_y,
  input  logic [DATA_W-1:0]  reg_z,
  output logic [FRAME_W-1:0] ctrl_frame,
  output int                 ctrl_writes,
  output int                 frame_count,
  output int                 addr_errors
);

  logic [FRAME_W-1:0] rx_shift = '0;
  logic [FRAME_W-1:0] tx_word  = '0;
  int                 bit_cnt  = 0; // rising sck edges seen in this frame

  function automatic logic [DATA_W-1:0] reg_read(input logic [ADDR_W-1:0] addr);
    case (addr)
      REG_OUT_X: reg_read = reg_x;
      REG_OUT_Y: reg_read = reg_y;
      REG_OUT_Z: reg_read = reg_z;
      default:   reg_read = '0;
    endcase
  endfunction

  initial begin
    miso        = 1'b0;
    ctrl_frame  = '0;
    ctrl_writes = 0;
    frame_count = 0;
    addr_errors = 0;
  end

  // cs rise closes a frame, sck rise shifts mosi in
  always @(posedge sck or posedge cs) begin
    logic [ADDR_W-1:0] addr;
    addr = rx_shift[FRAME_W-2 -: ADDR_W];
    if (cs) begin
      if (bit_cnt != 0) begin // skip the x to 1 step at reset
        frame_count = frame_count + 1;
        if (addr == REG_CTRL) begin
          ctrl_frame = rx_shift; // whole frame, read flag included
          if (rx_shift[FRAME_W-1]) begin
            addr_errors = addr_errors + 1;
          end else begin
            ctrl_writes = ctrl_writes + 1;
          end
        end else if (!rx_shift[FRAME_W-1] ||
                     !(addr inside {REG_OUT_X, REG_OUT_Y, REG_OUT_Z})) begin
          addr_errors = addr_errors + 1;
        end
      end
      bit_cnt  = 0;
      rx_shift = '0;
      tx_word  = '0;
    end else begin
      rx_shift = {rx_shift[FRAME_W-2:0], mosi};
      bit_cnt  = bit_cnt + 1;
      // read flag and address are in after the first eight bits
      if (bit_cnt == ADDR_W + 1 && rx_shift[ADDR_W]) begin
        tx_word = {{(FRAME_W - DATA_W){1'b0}}, reg_read(rx_shift[ADDR_W-1:0])};
      end
    end
  end

  // response bit changes on sck fall, first one at cs fall
  always @(negedge sck or negedge cs) begin
    if (cs === 1'b0 && bit_cnt < FRAME_W) begin
      miso <= tx_word[FRAME_W-1-bit_cnt];
    end
  end

endmodule

`default_nettype wire

//--- verif/tb_mems_spi_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_mems_spi_top import mems_pkg::*; ();

  localparam int CLK_DIV        = 2;
  localparam int N_FIXED        = 3;
  localparam int N_TESTS        = 8;
  localparam int SEED           = 29066;
  localparam int FRAME_CYCLES   = (FRAME_W + 2) * (2 ** CLK_DIV);
  localparam int TIMEOUT_CYCLES = N_TESTS * 4 * FRAME_CYCLES * 2;

  typedef struct packed {
    logic [DATA_W-1:0] x;
    logic [DATA_W-1:0] y;
    logic [DATA_W-1:0] z;
    logic              extra_req; // second request while busy
    logic [DATA_W-1:0] exp_x;
    logic [DATA_W-1:0] exp_y;
    logic [DATA_W-1:0] exp_z;
  } entry_t;

  logic               clk;
  logic               rst;
  logic               sample_req;
  logic               miso;
  logic               sck;
  logic               mosi;
  logic               cs;
  logic               seq_busy;
  logic               sample_valid;
  logic [DATA_W-1:0]  x_data;
  logic [DATA_W-1:0]  y_data;
  logic [DATA_W-1:0]  z_data;
  logic [DATA_W-1:0]  reg_x;
  logic [DATA_W-1:0]  reg_y;
  logic [DATA_W-1:0]  reg_z;
  logic [FRAME_W-1:0] ctrl_frame;
  int                 ctrl_writes;
  int                 frame_count;
  int                 addr_errors;

  entry_t stim [N_TESTS];
  int     error_count  = 0;
  int     sck_errors   = 0;
  int     test_count   = 0;
  int     tests_failed = 0;
  int     valid_count  = 0;
  int     cycle_count  = 0;

  mems_spi_top #(.CLK_DIV(CLK_DIV)) dut (
    .clk(clk), .rst(rst), .sample_req(sample_req), .miso(miso),
    .sck(sck), .mosi(mosi), .cs(cs), .seq_busy(seq_busy),
    .sample_valid(sample_valid), .x_data(x_data), .y_data(y_data), .z_data(z_data)
  );

  mems_slave_model u_slave (
    .sck(sck), .mosi(mosi), .cs(cs), .miso(miso),
    .reg_x(reg_x), .reg_y(reg_y), .reg_z(reg_z),
    .ctrl_frame(ctrl_frame), .ctrl_writes(ctrl_writes),
    .frame_count(frame_count), .addr_errors(addr_errors)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout, no result from the DUT after %0d cycles", cycle_count);
      $display("TEST FAIL");
      $finish;
    end
  end

  always @(negedge clk) begin
    if (sample_valid === 1'b1) valid_count <= valid_count + 1;
    // idle bus keeps sck low
    if (rst === 1'b0 && cs === 1'b1) begin
      assert (sck === 1'b0) else begin
        $display("sck is not low while cs is high, cycle %0d", cycle_count);
        sck_errors <= sck_errors + 1;
      end
    end
  end

  function automatic int total_errors();
    return error_count + sck_errors;
  endfunction

  task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("ERR %s got %h expected %h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    test_count++;
    if (total_errors() == errs_before) begin
      $display("test %0d %s ok", test_count, name);
    end else begin
      $display("test %0d %s failed, %0d errors", test_count, name, total_errors() - errs_before);
      tests_failed++;
    end
  endtask

  function automatic void set_entry(input int idx, input logic [DATA_W-1:0] x,
                                    input logic [DATA_W-1:0] y, input logic [DATA_W-1:0] z,
                                    input logic extra);
    stim[idx].x         = x;
    stim[idx].y         = y;
    stim[idx].z         = z;
    stim[idx].extra_req = extra;
    stim[idx].exp_x     = x; // sensor values come back unchanged
    stim[idx].exp_y     = y;
    stim[idx].exp_z     = z;
  endfunction

  function automatic void build_table();
    set_entry(0, 16'h0000, 16'hFFFF, 16'h8000, 1'b0);
    set_entry(1, 16'hFFFF, 16'h8000, 16'h0000, 1'b1);
    set_entry(2, 16'h8000, 16'h0000, 16'hFFFF, 1'b0);
    for (int i = N_FIXED; i < N_TESTS; i++) begin
      set_entry(i, DATA_W'($urandom), DATA_W'($urandom), DATA_W'($urandom), 1'(i % 2));
    end
  endfunction

  task automatic run_sample(input int idx);
    int errs;
    int valid_before;
    int frames_before;
    errs          = total_errors();
    valid_before  = valid_count;
    frames_before = frame_count;
    reg_x      = stim[idx].x;
    reg_y      = stim[idx].y;
    reg_z      = stim[idx].z;
    sample_req = 1'b1;
    @(negedge clk);
    sample_req = 1'b0;
    if (stim[idx].extra_req) begin
      repeat (4 * (2 ** CLK_DIV)) @(negedge clk); // well into the x frame
      check_hex("seq_busy", 32'(seq_busy), 32'h1);
      sample_req = 1'b1;
      @(negedge clk);
      sample_req = 1'b0;
    end
    while (sample_valid !== 1'b1) @(negedge clk);
    check_hex("x_data", 32'(x_data), 32'(stim[idx].exp_x));
    check_hex("y_data", 32'(y_data), 32'(stim[idx].exp_y));
    check_hex("z_data", 32'(z_data), 32'(stim[idx].exp_z));
    // room for a wrongly queued request to show up
    repeat (FRAME_CYCLES + 8) @(negedge clk);
    check_hex("sample_valid pulses", valid_count - valid_before, 32'd1);
    check_hex("frame_count delta", frame_count - frames_before, 32'd3);
    check_hex("addr_errors", addr_errors, 32'd0);
    finish_test($sformatf("sample %0d", idx), errs);
  endtask

  initial begin
    int errs;
    rst        = 1'b1;
    sample_req = 1'b0;
    reg_x      = '0;
    reg_y      = '0;
    reg_z      = '0;
    void'($urandom(SEED));
    build_table();
    repeat (2) @(negedge clk);

    errs = total_errors();
    check_hex("cs", 32'(cs), 32'h1);
    check_hex("sck", 32'(sck), 32'h0);
    check_hex("sample_valid", 32'(sample_valid), 32'h0);
    check_hex("seq_busy", 32'(seq_busy), 32'h1);
    rst = 1'b0;
    while (seq_busy !== 1'b0) @(negedge clk);
    check_hex("frame_count", frame_count, 32'd1);
    finish_test("reset and configuration", errs);

    errs = total_errors();
    check_hex("ctrl_writes", ctrl_writes, 32'd1);
    check_hex("ctrl_frame", 32'(ctrl_frame), 32'({1'b0, REG_CTRL, CTRL_INIT}));
    check_hex("ctrl read flag", 32'(ctrl_frame[FRAME_W-1]), 32'h0);
    finish_test("control write", errs);

    for (int i = 0; i < N_TESTS; i++) begin
      run_sample(i);
    end

    $display("tests %0d, failed %0d, errors %0d", test_count, tests_failed, total_errors());
    if (total_errors() == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
